/* i2s_hub.f */
+incdir+hw
hw/i2s_pkg.sv
hw/i2s_deserializer.sv
hw/frame_matcher.sv
hw/sync_fifo.sv
hw/link_merger.sv
hw/i2s_hub.sv
bench/i2s_link_driver.sv
bench/i2s_hub_tb.sv

/* bench/i2s_hub_tb.sv */
`timescale 1ns/1ps
`include "i2s_consts.svh"

module i2s_hub_tb
	import i2s_pkg::*;
;
	typedef byte_t byte_q_t[$];
	typedef tag_word_t word_q_t[$];

	localparam int FILLER_BYTES = 6;
	localparam int N_PLAYS = 9;
	localparam int PLAY_CLK = (FILLER_BYTES + `PACKET_BYTES + 1) * 4 * `I2S_SLOT_BITS;
	localparam int TIMEOUT_CYCLES = N_PLAYS * PLAY_CLK + 2000;

	logic clk = 1'b0;
	logic rst_n, out_ready, drop0, drop1, out_valid;
	logic bclk0, lrclk0, sdata0, bclk1, lrclk1, sdata1;
	tag_word_t out_word;
	integer seed = 64;
	int errors = 0;
	int n_words = 0;
	int cycles = 0;
	bit ready_low = 0;
	bit ready_random = 0;
	bit exp_drop0, exp_drop1;
	byte_t prev0 [`PAYLOAD_BYTES];
	byte_t prev1 [`PAYLOAD_BYTES];
	tag_word_t exp0[$];
	tag_word_t exp1[$];

	i2s_hub dut (.clk, .rst_n, .bclk0, .lrclk0, .sdata0, .bclk1, .lrclk1, .sdata1,
		.out_valid, .out_ready, .out_word, .drop0, .drop1);

	i2s_link_driver drv0 (.clk, .bclk(bclk0), .lrclk(lrclk0), .sdata(sdata0));
	i2s_link_driver drv1 (.clk, .bclk(bclk1), .lrclk(lrclk1), .sdata(sdata1));

	always #5 clk = ~clk;

	always @(negedge clk)
		out_ready <= ready_low ? 1'b0 : (ready_random ? 1'($random(seed)) : 1'b1);

	function automatic byte_t header_byte(input int i);
		return byte_t'(`HEADER_VALUE >> (8 * (`HEADER_BYTES - 1 - i)));
	endfunction

	// finds the packet, then passes its payload on only when it changed.
	function automatic word_q_t expected_words(input byte_q_t stream,
			inout byte_t prev [`PAYLOAD_BYTES], input logic [4:0] id, input bit busy,
			inout bit drop_flag);
		word_q_t words;
		tag_word_t w;
		int start;
		int base;
		bit differs;
		start = -1;
		for (int i = 0; i + `PACKET_BYTES <= stream.size() && start < 0; i++) begin
			start = i;
			for (int j = 0; j < `HEADER_BYTES; j++)
				if (stream[i+j] != header_byte(j))
					start = -1;
		end
		if (start < 0)
			return words;
		base = start + `PACKET_BYTES - `PAYLOAD_BYTES;
		differs = 0;
		for (int j = 0; j < `PAYLOAD_BYTES; j++)
			differs |= (stream[base+j] != prev[j]);
		if (differs && busy)
			drop_flag = 1'b1;
		else if (differs) begin
			for (int j = 0; j < `PAYLOAD_BYTES; j++) begin
				prev[j] = stream[base+j];
				w.zero = '0;
				w.link_id = id;
				w.payload = stream[base+j];
				words.push_back(w);
			end
		end
		return words;
	endfunction

	function automatic byte_q_t make_stream(input byte_t payload [`PAYLOAD_BYTES], input bit bad);
		byte_q_t s;
		for (int i = 0; i < FILLER_BYTES; i++)
			s.push_back(byte_t'($random(seed)));
		for (int i = 0; i < `HEADER_BYTES; i++)
			s.push_back(header_byte(i) ^ ((bad && i == 4) ? 8'h5A : 8'h00));
		for (int i = 0; i < `PACKET_BYTES - `HEADER_BYTES - `PAYLOAD_BYTES; i++)
			s.push_back(byte_t'($random(seed)));
		for (int i = 0; i < `PAYLOAD_BYTES; i++)
			s.push_back(payload[i]);
		return s;
	endfunction

	task automatic random_payload(output byte_t p [`PAYLOAD_BYTES]);
		foreach (p[i])
			p[i] = byte_t'($random(seed));
	endtask

	task automatic expect_link(input int link, input byte_q_t s, input bit busy);
		word_q_t words;
		if (link == 0) begin
			words = expected_words(s, prev0, 5'(`LINK0_ID), busy, exp_drop0);
			foreach (words[i])
				exp0.push_back(words[i]);
		end else begin
			words = expected_words(s, prev1, 5'(`LINK1_ID), busy, exp_drop1);
			foreach (words[i])
				exp1.push_back(words[i]);
		end
	endtask

	task automatic apply_reset();
		@(negedge clk);
		rst_n = 1'b0;
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		foreach (prev0[i]) begin
			prev0[i] = '0;  // the previous payload clears with the DUT.
			prev1[i] = '0;
		end
		exp_drop0 = 1'b0;
		exp_drop1 = 1'b0;
	endtask

	task automatic wait_drain();
		while (exp0.size() != 0 || exp1.size() != 0)
			@(posedge clk);
		repeat (32) @(posedge clk);
	endtask

	task automatic compare_word(input tag_word_t got);
		tag_word_t want;
		bit on_link1;
		bit have;
		on_link1 = (got.link_id == 5'(`LINK1_ID));
		have = on_link1 ? (exp1.size() != 0) :
			(got.link_id == 5'(`LINK0_ID) && exp0.size() != 0);
		assert (have) else begin
			errors++;
			$display("unexpected word %h at %0t ns, nothing was due from its link", got, $time);
		end
		if (have) begin
			if (on_link1)
				want = exp1.pop_front();
			else
				want = exp0.pop_front();
			assert (got == want) else begin
				errors++;
				$display("error at %0t ns: out_word got %h expected %h", $time, got, want);
			end
		end
	endtask

	always @(posedge clk) begin
		if (rst_n && out_valid && out_ready) begin
			n_words++;
			compare_word(out_word);
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TESTS FAILED");
			$finish;
		end
	end

	initial begin
		byte_t pay [`PAYLOAD_BYTES];
		byte_t pay2 [`PAYLOAD_BYTES];
		byte_q_t s, s2;
		rst_n = 1'b0;
		out_ready = 1'b1;
		apply_reset();
		assert (!out_valid && !drop0 && !drop1) else begin
			errors++;
			$display("out_valid or a drop flag is high after reset");
		end
		random_payload(pay);
		for (int n = 0; n < 3; n++) begin  // new, repeated, then changed payload.
			if (n == 2)
				random_payload(pay);
			s = make_stream(pay, 1'b0);
			expect_link(0, s, 1'b0);
			drv0.play(s);
			wait_drain();
		end
		apply_reset();
		random_payload(pay);
		foreach (pay2[i])
			pay2[i] = '0;
		for (int n = 0; n < 3; n++) begin  // bad header and zero payload, then two clean rounds.
			s = make_stream(pay, n == 0);
			s2 = make_stream(pay2, 1'b0);
			expect_link(0, s, 1'b0);
			expect_link(1, s2, 1'b0);
			ready_random = (n == 2);
			fork
				drv0.play(s);
				drv1.play(s2);
			join
			wait_drain();
			random_payload(pay);
			random_payload(pay2);
		end
		ready_random = 1'b0;
		ready_low = 1'b1;
		for (int n = 0; n < 2; n++) begin
			random_payload(pay);
			s2 = make_stream(pay, 1'b0);
			expect_link(1, s2, n == 1);  // the first release is still stalled.
			drv1.play(s2);
		end
		ready_low = 1'b0;
		wait_drain();
		// the dropped payload once more, which still differs from the first one.
		s2 = make_stream(pay, 1'b0);
		expect_link(1, s2, 1'b0);
		drv1.play(s2);
		wait_drain();
		assert (exp0.size() == 0 && exp1.size() == 0) else begin
			errors++;
			$display("expected words never appeared on the output");
		end
		assert (drop0 == exp_drop0) else begin
			errors++;
			$display("error at %0t ns: drop0 got %b expected %b", $time, drop0, exp_drop0);
		end
		assert (drop1 == exp_drop1) else begin
			errors++;
			$display("error at %0t ns: drop1 got %b expected %b", $time, drop1, exp_drop1);
		end
		$display("checked %0d words, %0d errors", n_words, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

/* bench/i2s_link_driver.sv */
`timescale 1ns/1ps
`include "i2s_consts.svh"

module i2s_link_driver
	import i2s_pkg::*;
(
	input  logic clk,
	output logic bclk,
	output logic lrclk,
	output logic sdata
);
	integer seed = 64;
	logic   tail = 1'b0;  // last bit of a slot goes out after the lrclk change.

	initial begin
		bclk = 1'b0;
		lrclk = 1'b1;  // idle in the right slot.
		sdata = 1'b0;
	end

	// one slot of 32 bit clocks, bclk toggling every 2 clk.
	task automatic play_slot(input logic left, input logic [`I2S_SLOT_BITS-1:0] word);
		for (int k = 0; k < `I2S_SLOT_BITS; k++) begin
			@(negedge clk);
			bclk = 1'b0;
			if (k == 0)
				lrclk = !left;
			sdata = (k == 0) ? tail : word[`I2S_SLOT_BITS - k];
			repeat (2) @(negedge clk);
			bclk = 1'b1;
			@(negedge clk);
		end
		tail = word[0];
	endtask

	// two bytes per left slot, most significant byte first.
	task automatic play(input byte_t data[$]);
		integer r;
		r = $random(seed);
		play_slot(1'b0, {r[23:0], 8'h00});
		for (int i = 0; i + 1 < data.size(); i += 2) begin
			r = $random(seed);
			play_slot(1'b1, {data[i], data[i+1], r[7:0], 8'h00});
			r = $random(seed);
			play_slot(1'b0, {r[23:0], 8'h00});  // right slot carries noise only.
		end
	endtask

endmodule

/* hw/i2s_hub.sv */
`timescale 1ns/1ps
`include "i2s_consts.svh"

module i2s_hub
	import i2s_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      bclk0,
	input  logic      lrclk0,
	input  logic      sdata0,
	input  logic      bclk1,
	input  logic      lrclk1,
	input  logic      sdata1,
	output logic      out_valid,
	input  logic      out_ready,
	output tag_word_t out_word,
	output logic      drop0,
	output logic      drop1
);
	logic                    s_valid0, s_valid1;
	logic [`SAMPLE_BITS-1:0] sample0, sample1;
	logic                    m_valid0, m_valid1;
	logic                    m_ready0, m_ready1;
	byte_t                   m_data0, m_data1;
	logic                    l_valid0, l_valid1;
	logic                    l_ready0, l_ready1;
	byte_t                   l_data0, l_data1;
	logic                    word_valid;
	logic                    word_ready;
	tag_word_t               word_data;

	i2s_deserializer deser0 (.clk, .rst_n, .bclk(bclk0), .lrclk(lrclk0), .sdata(sdata0),
		.sample_valid(s_valid0), .sample(sample0));

	i2s_deserializer deser1 (.clk, .rst_n, .bclk(bclk1), .lrclk(lrclk1), .sdata(sdata1),
		.sample_valid(s_valid1), .sample(sample1));

	frame_matcher match0 (.clk, .rst_n, .sample_valid(s_valid0), .sample(sample0),
		.byte_valid(m_valid0), .byte_ready(m_ready0), .byte_data(m_data0), .drop(drop0));

	frame_matcher match1 (.clk, .rst_n, .sample_valid(s_valid1), .sample(sample1),
		.byte_valid(m_valid1), .byte_ready(m_ready1), .byte_data(m_data1), .drop(drop1));

	sync_fifo #(.payload_t(byte_t), .DEPTH(`LINK_FIFO_DEPTH)) fifo0 (
		.clk, .rst_n,
		.in_valid(m_valid0), .in_ready(m_ready0), .in_data(m_data0),
		.out_valid(l_valid0), .out_ready(l_ready0), .out_data(l_data0));

	sync_fifo #(.payload_t(byte_t), .DEPTH(`LINK_FIFO_DEPTH)) fifo1 (
		.clk, .rst_n,
		.in_valid(m_valid1), .in_ready(m_ready1), .in_data(m_data1),
		.out_valid(l_valid1), .out_ready(l_ready1), .out_data(l_data1));

	link_merger merger (
		.clk, .rst_n,
		.a_valid(l_valid0), .a_ready(l_ready0), .a_data(l_data0),
		.b_valid(l_valid1), .b_ready(l_ready1), .b_data(l_data1),
		.word_valid, .word_ready, .word_data);

	// the output FIFO keeps the merger's combinational path off the outputs.
	sync_fifo #(.payload_t(tag_word_t), .DEPTH(`OUT_FIFO_DEPTH)) out_fifo (
		.clk, .rst_n,
		.in_valid(word_valid), .in_ready(word_ready), .in_data(word_data),
		.out_valid, .out_ready, .out_data(out_word));

endmodule

/* hw/link_merger.sv */
`timescale 1ns/1ps
`include "i2s_consts.svh"

module link_merger
	import i2s_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      a_valid,
	output logic      a_ready,
	input  byte_t     a_data,
	input  logic      b_valid,
	output logic      b_ready,
	input  byte_t     b_data,
	output logic      word_valid,
	input  logic      word_ready,
	output tag_word_t word_data
);
	logic last_b;  // b won the last transfer.
	logic hold;
	logic hold_b;
	logic sel_b;

	// a stalled word keeps its source so its data cannot change.
	assign sel_b = hold ? hold_b : (b_valid && (!a_valid || !last_b));

	assign word_valid = a_valid | b_valid;
	assign a_ready = word_ready & ~sel_b;
	assign b_ready = word_ready & sel_b;

	always_comb begin
		word_data.zero = '0;
		if (sel_b) begin
			word_data.link_id = 5'(`LINK1_ID);
			word_data.payload = b_data;
		end else begin
			word_data.link_id = 5'(`LINK0_ID);
			word_data.payload = a_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			last_b <= 1'b0;
			hold <= 1'b0;
			hold_b <= 1'b0;
		end else if (word_valid && word_ready) begin
			last_b <= sel_b;
			hold <= 1'b0;
		end else if (word_valid) begin
			hold <= 1'b1;
			hold_b <= sel_b;
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		word_valid && !word_ready |=> word_valid && $stable(word_data));

endmodule

/* hw/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  DEPTH     = 4
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     in_valid,
	output logic     in_ready,
	input  payload_t in_data,
	output logic     out_valid,
	input  logic     out_ready,
	output payload_t out_data
);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t         mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             push;
	logic             pop;

	assign out_valid = (count != '0);
	assign in_ready = (count != CNT_W'(DEPTH)) | out_ready;  // a pop frees the slot.
	assign out_data = mem[rd_ptr];
	assign push = in_valid & in_ready;
	assign pop = out_valid & out_ready;

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= in_data;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n) count <= CNT_W'(DEPTH));

endmodule

/* hw/frame_matcher.sv */
`timescale 1ns/1ps
`include "i2s_consts.svh"

module frame_matcher
	import i2s_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    sample_valid,
	input  logic [`SAMPLE_BITS-1:0] sample,
	output logic                    byte_valid,
	input  logic                    byte_ready,
	output byte_t                   byte_data,
	output logic                    drop
);
	localparam int HIST_W = `PAYLOAD_BYTES * 8;
	localparam int HDR_W = `HEADER_BYTES * 8;
	localparam int CNT_W = $clog2(`PACKET_BYTES + 1);
	localparam int REL_W = $clog2(`PAYLOAD_BYTES + 1);

	typedef enum logic {
		SEARCH,
		COUNT
	} state_t;

	state_t            state;
	logic              pend_valid;
	byte_t             pend_byte;
	logic              in_valid;
	byte_t             in_byte;
	logic [HIST_W-1:0] hist;
	logic [HIST_W-1:0] prev;
	logic [HIST_W-1:0] rel_buf;
	logic [CNT_W-1:0]  byte_cnt;
	logic              pkt_end;
	logic [REL_W-1:0]  rel_cnt;
	logic              hdr_hit;
	logic              changed;
	logic              load;
	logic              fire;

	// the high byte goes in with the sample, the low byte one clk later.
	assign in_valid = sample_valid | pend_valid;
	assign in_byte = sample_valid ? sample[`SAMPLE_BITS-1 -: 8] : pend_byte;

	assign hdr_hit = (hist[HDR_W-1:0] == `HEADER_VALUE);
	assign changed = pkt_end && (hist != prev);
	assign load = changed && !byte_valid;
	assign fire = byte_valid & byte_ready;
	assign byte_data = rel_buf[HIST_W-1 -: 8];  // oldest byte sits on top.

	always_ff @(posedge clk) begin
		if (!rst_n)
			pend_valid <= 1'b0;
		else
			pend_valid <= sample_valid;
	end

	always_ff @(posedge clk) begin
		if (sample_valid)
			pend_byte <= sample[7:0];
		if (in_valid)
			hist <= {hist[HIST_W-9:0], in_byte};  // newest byte at the bottom.
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= SEARCH;
			byte_cnt <= '0;
			pkt_end <= 1'b0;
		end else begin
			pkt_end <= 1'b0;
			case (state)
				SEARCH: begin
					if (hdr_hit) begin
						// a byte arriving now is already the eleventh.
						state <= COUNT;
						byte_cnt <= CNT_W'(`HEADER_BYTES) + CNT_W'(in_valid);
					end
				end
				COUNT: begin
					if (in_valid) begin
						byte_cnt <= byte_cnt + 1'b1;
						if (byte_cnt == CNT_W'(`PACKET_BYTES - 1)) begin
							state <= SEARCH;
							pkt_end <= 1'b1;
						end
					end
				end
				default: state <= SEARCH;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			byte_valid <= 1'b0;
			rel_cnt <= '0;
			prev <= '0;
			drop <= 1'b0;
		end else begin
			if (fire) begin
				rel_cnt <= rel_cnt - 1'b1;
				if (rel_cnt == REL_W'(1))
					byte_valid <= 1'b0;
			end
			if (changed && byte_valid)
				drop <= 1'b1;  // links cannot stall, so the new payload is lost.
			if (load) begin
				prev <= hist;
				rel_cnt <= REL_W'(`PAYLOAD_BYTES);
				byte_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load)
			rel_buf <= hist;
		else if (fire)
			rel_buf <= rel_buf << 8;
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		byte_valid && !byte_ready |=> byte_valid && $stable(byte_data));

endmodule

/* hw/i2s_deserializer.sv */
`timescale 1ns/1ps
`include "i2s_consts.svh"

module i2s_deserializer (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    bclk,
	input  logic                    lrclk,
	input  logic                    sdata,
	output logic                    sample_valid,
	output logic [`SAMPLE_BITS-1:0] sample
);
	localparam int CNT_W = $clog2(`I2S_SLOT_BITS);

	logic [1:0]                bclk_sync;
	logic [1:0]                lrclk_sync;
	logic [1:0]                sdata_sync;
	logic                      bclk_prev;
	logic                      lr_prev;
	logic [CNT_W-1:0]          bit_cnt;
	logic [`I2S_DATA_BITS-1:0] shreg;
	logic [`I2S_DATA_BITS-1:0] shifted;
	logic                      bclk_rise;
	logic                      data_bit;
	logic                      last_bit;

	assign bclk_rise = bclk_sync[1] & ~bclk_prev;
	assign shifted = {shreg[`I2S_DATA_BITS-2:0], sdata_sync[1]};

	// a bit of the left slot, lrclk unchanged since the previous edge and low.
	assign data_bit = bclk_rise && (lrclk_sync[1] == lr_prev) && !lr_prev &&
		(bit_cnt < CNT_W'(`I2S_DATA_BITS));
	assign last_bit = data_bit && (bit_cnt == CNT_W'(`I2S_DATA_BITS - 1));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			bclk_sync <= '0;
			lrclk_sync <= '0;
			sdata_sync <= '0;
			bclk_prev <= 1'b0;
		end else begin
			bclk_sync <= {bclk_sync[0], bclk};
			lrclk_sync <= {lrclk_sync[0], lrclk};
			sdata_sync <= {sdata_sync[0], sdata};
			bclk_prev <= bclk_sync[1];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			lr_prev <= 1'b0;
			bit_cnt <= '1;  // parked until the first slot boundary.
			sample_valid <= 1'b0;
		end else begin
			sample_valid <= last_bit;
			if (bclk_rise) begin
				if (lrclk_sync[1] != lr_prev) begin
					// this edge still carries the last bit of the old slot.
					lr_prev <= lrclk_sync[1];
					bit_cnt <= '0;
				end else if (bit_cnt != CNT_W'(`I2S_SLOT_BITS - 1)) begin
					bit_cnt <= bit_cnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (data_bit)
			shreg <= shifted;
		if (last_bit)
			sample <= shifted[`I2S_DATA_BITS-1 -: `SAMPLE_BITS];  // top bits only.
	end

	assert property (@(posedge clk) disable iff (!rst_n) sample_valid |=> !sample_valid);

endmodule

/* hw/i2s_pkg.sv */
package i2s_pkg;

	typedef logic [7:0] byte_t;  // one payload byte.

	// output word, three zero bits above the link ID and the byte.
	typedef struct packed {
		logic [2:0] zero;
		logic [4:0] link_id;
		byte_t      payload;
	} tag_word_t;

endpackage

/* hw/i2s_consts.svh */
`ifndef I2S_CONSTS_SVH
`define I2S_CONSTS_SVH

// serial frame layout.
`define I2S_SLOT_BITS 32
`define I2S_DATA_BITS 24
`define SAMPLE_BITS 16

// packet framing. the header is written oldest byte first.
`define HEADER_BYTES 10
`define HEADER_VALUE 80'h0B_77_A1_DD_42_40_2F_84_2B_03
`define PACKET_BYTES 174
`define PAYLOAD_BYTES 15

// IDs carried in the output word.
`define LINK0_ID 3
`define LINK1_ID 17

`define LINK_FIFO_DEPTH 8
`define OUT_FIFO_DEPTH 4

`endif
